/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ifu_top
RTL_TOP   ?= ifu_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/ifu_bus_pkg.sv */
`default_nettype none

package ifu_bus_pkg;

  // axi4-lite address read channel payload
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axil_ar_t;

  // axi4-lite read data channel payload
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  // fetch request from the pc generator, carried along with the word
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] pred_npc;
    logic        pred_taken;
  } fetch_req_t;

  // what the decode stage receives
  typedef struct packed {
    logic [31:0]              pc;
    logic [31:0]              inst;
    logic [31:0]              pred_npc;
    logic                     pred_taken;
    rv_isa_pkg::inst_class_e  cls;
  } fetch_bundle_t;

  // resolved control transfer from the back end
  // target is the correct next pc, also for a not-taken branch
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] target;
    logic        taken;
  } redirect_t;

endpackage

`default_nettype wire

/* hdl/ifu_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_icache #(
  parameter int IC_SETS_LOG2 = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst,

  input  wire ifu_bus_pkg::fetch_req_t req_i,
  input  wire logic                    req_valid_i,
  output logic                         req_ready_o,

  output ifu_bus_pkg::fetch_req_t      resp_o,
  output logic [31:0]                  inst_o,
  output logic                         resp_valid_o,
  input  wire logic                    resp_ready_i,

  input  wire logic                    kill_i,
  input  wire logic                    flush_i,

  output ifu_bus_pkg::axil_ar_t        m_ar_o,
  output logic                         m_arvalid_o,
  input  wire logic                    m_arready_i,
  input  wire ifu_bus_pkg::axil_r_t    m_r_i,
  input  wire logic                    m_rvalid_i,
  output logic                         m_rready_o
);

  import ifu_bus_pkg::*;

  localparam int SETS  = 1 << IC_SETS_LOG2;
  localparam int TAG_W = 29 - IC_SETS_LOG2;

  typedef enum logic [2:0] {
    IDLE,
    AR_LO,
    R_LO,
    AR_HI,
    R_HI,
    DONE
  } refill_state_e;

  refill_state_e state_q;

  logic [SETS-1:0]  line_valid_q;
  logic [TAG_W-1:0] tag_q [SETS];
  logic [31:0]      data_q [SETS][2];

  // pc[31:3] of the line being refilled
  logic [28:0]      miss_line_q;

  fetch_req_t       resp_q;
  logic [31:0]      inst_q;
  logic             resp_valid_q;

  logic [TAG_W-1:0]        req_tag;
  logic [IC_SETS_LOG2-1:0] req_idx;
  logic                    req_off;
  logic [TAG_W-1:0]        fill_tag;
  logic [IC_SETS_LOG2-1:0] fill_idx;
  logic                    hit;
  logic                    slot_free;
  logic                    req_fire;
  logic                    miss_start;
  logic                    ar_hi;

  // pc = {tag, index, word offset, 2'b00}
  assign req_tag  = req_i.pc[31:IC_SETS_LOG2+3];
  assign req_idx  = req_i.pc[IC_SETS_LOG2+2:3];
  assign req_off  = req_i.pc[2];
  assign fill_tag = miss_line_q[28:IC_SETS_LOG2];
  assign fill_idx = miss_line_q[IC_SETS_LOG2-1:0];

  assign hit       = line_valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign slot_free = !resp_valid_q || resp_ready_i;

  // no lookup on a redirect or flush cycle, the request there is stale
  assign req_ready_o = (state_q == IDLE || state_q == DONE) && hit && slot_free &&
                       !kill_i && !flush_i;
  assign req_fire    = req_valid_i && req_ready_o;
  assign miss_start  = (state_q == IDLE) && req_valid_i && !hit && !kill_i;

  assign ar_hi       = (state_q == AR_HI);
  assign m_arvalid_o = (state_q == AR_LO) || (state_q == AR_HI);
  assign m_rready_o  = (state_q == R_LO) || (state_q == R_HI);
  // prot[2] marks an instruction access
  assign m_ar_o      = '{addr: {miss_line_q, ar_hi, 2'b00}, prot: 3'b100};

  assign resp_o       = resp_q;
  assign inst_o       = inst_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      line_valid_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_start) begin
            state_q               <= AR_LO;
            // the set is rewritten word by word, so it must not hit meanwhile
            line_valid_q[req_idx] <= 1'b0;
          end
        end
        AR_LO: if (m_arready_i) state_q <= R_LO;
        R_LO:  if (m_rvalid_i) state_q <= AR_HI;
        AR_HI: if (m_arready_i) state_q <= R_HI;
        R_HI: begin
          if (m_rvalid_i) begin
            state_q                <= DONE;
            line_valid_q[fill_idx] <= 1'b1;
          end
        end
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
      if (flush_i) begin
        line_valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      miss_line_q <= req_i.pc[31:3];
    end
    if (state_q == R_LO && m_rvalid_i) begin
      data_q[fill_idx][0] <= m_r_i.data;
    end
    if (state_q == R_HI && m_rvalid_i) begin
      data_q[fill_idx][1] <= m_r_i.data;
      tag_q[fill_idx]     <= fill_tag;
    end
  end

  // registered hit result, one entry
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid_q <= 1'b0;
    end else if (kill_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      resp_q <= req_i;
      inst_q <= data_q[req_idx][req_off];
    end
  end

endmodule

`default_nettype wire

/* hdl/ifu_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_gen #(
  parameter logic [31:0] PC_INIT          = 32'h8000_0000,
  parameter int          BTB_ENTRIES_LOG2 = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire ifu_bus_pkg::redirect_t  redirect_i,
  input  wire logic                    redirect_valid_i,
  output ifu_bus_pkg::fetch_req_t      req_o,
  output logic                         req_valid_o,
  input  wire logic                    req_ready_i
);

  localparam int BTB_N     = 1 << BTB_ENTRIES_LOG2;
  localparam int BTB_TAG_W = 30 - BTB_ENTRIES_LOG2;

  logic [31:0]           pc_q;
  logic                  valid_q;

  logic [BTB_N-1:0]      btb_valid_q;
  logic [BTB_TAG_W-1:0]  btb_tag_q [BTB_N];
  logic [31:0]           btb_target_q [BTB_N];

  logic [BTB_ENTRIES_LOG2-1:0] rd_idx;
  logic [BTB_ENTRIES_LOG2-1:0] wr_idx;
  logic [BTB_TAG_W-1:0]        rd_tag;
  logic [BTB_TAG_W-1:0]        wr_tag;
  logic                        btb_hit;
  logic [31:0]                 pc_next;

  // lookup on the current fetch pc
  assign rd_idx = pc_q[BTB_ENTRIES_LOG2+1:2];
  assign rd_tag = pc_q[31:BTB_ENTRIES_LOG2+2];

  // training uses the pc of the resolved branch
  assign wr_idx = redirect_i.pc[BTB_ENTRIES_LOG2+1:2];
  assign wr_tag = redirect_i.pc[31:BTB_ENTRIES_LOG2+2];

  assign btb_hit = btb_valid_q[rd_idx] && (btb_tag_q[rd_idx] == rd_tag);
  assign pc_next = btb_hit ? btb_target_q[rd_idx] : pc_q + 32'd4;

  assign req_o = '{pc: pc_q, pred_npc: pc_next, pred_taken: btb_hit};
  assign req_valid_o = valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      // a redirect beats whatever was predicted
      if (redirect_valid_i) begin
        pc_q <= redirect_i.target;
      end else if (req_valid_o && req_ready_i) begin
        pc_q <= pc_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= '0;
    end else if (redirect_valid_i) begin
      // taken fills the entry, not taken drops it
      btb_valid_q[wr_idx] <= redirect_i.taken;
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_valid_i && redirect_i.taken) begin
      btb_tag_q[wr_idx]    <= wr_tag;
      btb_target_q[wr_idx] <= redirect_i.target;
    end
  end

endmodule

`default_nettype wire

/* hdl/ifu_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_predecode (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire ifu_bus_pkg::fetch_req_t resp_i,
  input  wire logic [31:0]             inst_i,
  input  wire logic                    resp_valid_i,
  output logic                         resp_ready_o,
  input  wire logic                    kill_i,
  output ifu_bus_pkg::fetch_bundle_t   fetch_o,
  output logic                         fetch_valid_o,
  input  wire logic                    fetch_ready_i,
  output logic                         flush_o
);

  import rv_isa_pkg::*;

  function automatic inst_class_e classify(input logic [31:0] inst);
    opcode_e     opc;
    inst_class_e cls;
    opc = opcode_e'(inst[6:0]);
    case (opc)
      OPC_JAL, OPC_JALR: cls = CLS_JUMP;
      OPC_BRANCH:        cls = CLS_BRANCH;
      OPC_SYSTEM:        cls = CLS_SYSTEM;
      // plain fence stays sequential
      OPC_MISC_MEM:      cls = (inst == INST_FENCE_I) ? CLS_FENCE_I : CLS_SEQ;
      default:           cls = CLS_SEQ;
    endcase
    return cls;
  endfunction

  assign resp_ready_o = !fetch_valid_o || fetch_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_valid_o <= 1'b0;
    end else if (kill_i) begin
      fetch_valid_o <= 1'b0;
    end else if (resp_ready_o) begin
      fetch_valid_o <= resp_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_valid_i && resp_ready_o) begin
      fetch_o.pc         <= resp_i.pc;
      fetch_o.inst       <= inst_i;
      fetch_o.pred_npc   <= resp_i.pred_npc;
      fetch_o.pred_taken <= resp_i.pred_taken;
      fetch_o.cls        <= classify(inst_i);
    end
  end

  // cache invalidate once fence.i has left for decode
  assign flush_o = fetch_valid_o && fetch_ready_i && (fetch_o.cls == CLS_FENCE_I);

endmodule

`default_nettype wire

/* hdl/ifu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifu_top #(
  parameter logic [31:0] PC_INIT          = 32'h8000_0000,
  parameter int          IC_SETS_LOG2     = 2,
  parameter int          BTB_ENTRIES_LOG2 = 2
) (
  input  wire logic                     clk,
  input  wire logic                     rst,

  input  wire ifu_bus_pkg::redirect_t   redirect_i,
  input  wire logic                     redirect_valid_i,

  output ifu_bus_pkg::fetch_bundle_t    fetch_o,
  output logic                          fetch_valid_o,
  input  wire logic                     fetch_ready_i,

  output ifu_bus_pkg::axil_ar_t         m_ar_o,
  output logic                          m_arvalid_o,
  input  wire logic                     m_arready_i,
  input  wire ifu_bus_pkg::axil_r_t     m_r_i,
  input  wire logic                     m_rvalid_i,
  output logic                          m_rready_o
);

  import ifu_bus_pkg::*;

  fetch_req_t  req;
  logic        req_valid;
  logic        req_ready;
  fetch_req_t  resp;
  logic [31:0] resp_inst;
  logic        resp_valid;
  logic        resp_ready;
  logic        flush;

  ifu_pc_gen #(
    .PC_INIT          (PC_INIT),
    .BTB_ENTRIES_LOG2 (BTB_ENTRIES_LOG2)
  ) ifu_pc_gen_i (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect_i),
    .redirect_valid_i (redirect_valid_i),
    .req_o            (req),
    .req_valid_o      (req_valid),
    .req_ready_i      (req_ready)
  );

  ifu_icache #(
    .IC_SETS_LOG2 (IC_SETS_LOG2)
  ) ifu_icache_i (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .resp_o       (resp),
    .inst_o       (resp_inst),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .kill_i       (redirect_valid_i),
    .flush_i      (flush),
    .m_ar_o       (m_ar_o),
    .m_arvalid_o  (m_arvalid_o),
    .m_arready_i  (m_arready_i),
    .m_r_i        (m_r_i),
    .m_rvalid_i   (m_rvalid_i),
    .m_rready_o   (m_rready_o)
  );

  ifu_predecode ifu_predecode_i (
    .clk           (clk),
    .rst           (rst),
    .resp_i        (resp),
    .inst_i        (resp_inst),
    .resp_valid_i  (resp_valid),
    .resp_ready_o  (resp_ready),
    .kill_i        (redirect_valid_i),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .flush_o       (flush)
  );

endmodule

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // coarse class handed to decode with each fetched word
  typedef enum logic [2:0] {
    CLS_SEQ     = 3'd0,
    CLS_JUMP    = 3'd1,
    CLS_BRANCH  = 3'd2,
    CLS_SYSTEM  = 3'd3,
    CLS_FENCE_I = 3'd4
  } inst_class_e;

  // fence.i with rd, rs1 and imm all zero, funct3 = 001
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

endpackage

`default_nettype wire

/* sim/tb_axil_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_mem #(
  parameter int WORDS_LOG2 = 8
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire ifu_bus_pkg::axil_ar_t ar_i,
  input  wire logic                  arvalid_i,
  output logic                       arready_o,
  output ifu_bus_pkg::axil_r_t       r_o,
  output logic                       rvalid_o,
  input  wire logic                  rready_i
);

  import rv_isa_pkg::*;

  logic [31:0] mem [1 << WORDS_LOG2];
  logic [31:0] lfsr;
  logic        pend;
  logic [31:0] pend_addr;
  logic        armed;
  logic [1:0]  delay;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // opcode picked from the address, never MISC_MEM, upper bits from the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    logic [2:0] sel;
    opcode_e    opc;
    sel = a[4:2] ^ a[7:5] ^ a[10:8];
    case (sel)
      3'd0:    opc = OPC_LUI;
      3'd1:    opc = OPC_AUIPC;
      3'd2:    opc = OPC_JAL;
      3'd3:    opc = OPC_JALR;
      3'd4:    opc = OPC_BRANCH;
      3'd5:    opc = OPC_LOAD;
      3'd6:    opc = OPC_OP_IMM;
      default: opc = OPC_SYSTEM;
    endcase
    return {a[31:7] ^ a[26:2], opc};
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[WORDS_LOG2+1:2]] = data;
  endtask

  initial begin
    for (int i = 0; i < (1 << WORDS_LOG2); i++) begin
      mem[i] = fill_word(32'(i) << 2);
    end
    lfsr      = 32'h33185de0;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    r_o       = '0;
    armed     = 1'b0;
    delay     = 2'd0;
  end

  always @(posedge clk) begin
    if (rst) begin
      pend <= 1'b0;
    end else if (arvalid_i && arready_o) begin
      pend      <= 1'b1;
      pend_addr <= ar_i.addr;
    end else if (rvalid_o && rready_i) begin
      pend <= 1'b0;
    end
  end

  // outputs change on the falling edge only
  always @(negedge clk) begin
    if (rst || !pend) begin
      rvalid_o = 1'b0;
      armed    = 1'b0;
      if (rst) begin
        arready_o = 1'b0;
      end else begin
        lfsr      = lfsr_next(lfsr);
        arready_o = lfsr[0];
      end
    end else begin
      arready_o = 1'b0;
      if (!armed) begin
        lfsr     = lfsr_next(lfsr);
        delay[0] = lfsr[0];
        lfsr     = lfsr_next(lfsr);
        delay[1] = lfsr[0];
        armed    = 1'b1;
      end
      if (!rvalid_o) begin
        if (delay == 2'd0) begin
          rvalid_o = 1'b1;
          r_o      = '{data: mem[pend_addr[WORDS_LOG2+1:2]], resp: 2'b00};
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_ifu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_top;

  import rv_isa_pkg::*;
  import ifu_bus_pkg::*;

  localparam logic [31:0] PC_INIT   = 32'h0000_0040;
  localparam int          NUM_STEPS = 10;
  localparam int          CLK_NS    = 4;

  typedef struct packed {
    logic [7:0]  n;
    logic        rd_v;
    logic [31:0] rd_pc;
    logic [31:0] rd_tgt;
    logic        rd_taken;
    logic        wr_v;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic        rnd;
  } step_t;

  logic          clk;
  logic          rst;
  redirect_t     redirect;
  logic          redirect_valid;
  fetch_bundle_t fetch;
  logic          fetch_valid;
  logic          fetch_ready;
  axil_ar_t      m_ar;
  logic          m_arvalid;
  logic          m_arready;
  axil_r_t       m_r;
  logic          m_rvalid;
  logic          m_rready;

  step_t         steps [NUM_STEPS];
  logic [31:0]   lfsr;
  logic [31:0]   exp_pc;
  // btb and cache residency models of four entries each
  logic          btb_v [4];
  logic [27:0]   btb_tag [4];
  logic [31:0]   btb_tgt [4];
  logic          line_v [4];
  logic [28:0]   line_addr [4];
  logic [28:0]   refill_line;
  logic          ar_upper_next;
  logic          hi_pending;
  logic          r_outstanding;
  logic          fence_going;
  fetch_bundle_t held;
  logic          held_v;

  ifu_top #(
    .PC_INIT          (PC_INIT),
    .IC_SETS_LOG2     (2),
    .BTB_ENTRIES_LOG2 (2)
  ) ifu_top_i (
    .clk              (clk),
    .rst              (rst),
    .redirect_i       (redirect),
    .redirect_valid_i (redirect_valid),
    .fetch_o          (fetch),
    .fetch_valid_o    (fetch_valid),
    .fetch_ready_i    (fetch_ready),
    .m_ar_o           (m_ar),
    .m_arvalid_o      (m_arvalid),
    .m_arready_i      (m_arready),
    .m_r_i            (m_r),
    .m_rvalid_i       (m_rvalid),
    .m_rready_o       (m_rready)
  );

  tb_axil_mem mem_i (
    .clk       (clk),
    .rst       (rst),
    .ar_i      (m_ar),
    .arvalid_i (m_arvalid),
    .arready_o (m_arready),
    .r_o       (m_r),
    .rvalid_o  (m_rvalid),
    .rready_i  (m_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bundle(input string name, input fetch_bundle_t got,
                              input fetch_bundle_t exp);
    if (got.pc !== exp.pc)
      stop_run($sformatf("FAIL t=%0t %s.pc got %h expected %h", $time, name, got.pc, exp.pc));
    if (got.inst !== exp.inst)
      stop_run($sformatf("FAIL t=%0t %s.inst got %h expected %h", $time, name, got.inst,
                         exp.inst));
    if (got.pred_npc !== exp.pred_npc)
      stop_run($sformatf("FAIL t=%0t %s.pred_npc got %h expected %h", $time, name,
                         got.pred_npc, exp.pred_npc));
    if (got.pred_taken !== exp.pred_taken)
      stop_run($sformatf("FAIL t=%0t %s.pred_taken got %b expected %b", $time, name,
                         got.pred_taken, exp.pred_taken));
  endtask

  task automatic check_class(input string name, input inst_class_e got, input inst_class_e exp);
    if (got !== exp)
      stop_run($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
  endtask

  function automatic inst_class_e expected_class(input logic [31:0] inst);
    if (inst == INST_FENCE_I) return CLS_FENCE_I;
    if (inst[6:0] == 7'b1101111 || inst[6:0] == 7'b1100111) return CLS_JUMP;
    if (inst[6:0] == 7'b1100011) return CLS_BRANCH;
    if (inst[6:0] == 7'b1110011) return CLS_SYSTEM;
    return CLS_SEQ;
  endfunction

  function automatic fetch_bundle_t expected_bundle(input logic [31:0] pc);
    fetch_bundle_t b;
    logic          hit;
    hit          = btb_v[pc[3:2]] && (btb_tag[pc[3:2]] == pc[31:4]);
    b.pc         = pc;
    b.inst       = mem_i.mem[pc[9:2]];
    b.pred_taken = hit;
    b.pred_npc   = hit ? btb_tgt[pc[3:2]] : pc + 32'd4;
    b.cls        = expected_class(b.inst);
    return b;
  endfunction

  task automatic run_step(input step_t st);
    int            accepted;
    logic          ready;
    fetch_bundle_t exp;
    accepted = 0;
    if (st.wr_v) mem_i.write_word(st.wr_addr, st.wr_data);
    if (st.rd_v) begin
      @(negedge clk);
      fence_going    = 1'b0;
      fetch_ready    = 1'b0;
      redirect       = '{pc: st.rd_pc, target: st.rd_tgt, taken: st.rd_taken};
      redirect_valid = 1'b1;
      btb_v[st.rd_pc[3:2]] = st.rd_taken;
      if (st.rd_taken) begin
        btb_tag[st.rd_pc[3:2]] = st.rd_pc[31:4];
        btb_tgt[st.rd_pc[3:2]] = st.rd_tgt;
      end
      exp_pc = st.rd_tgt;
      held_v = 1'b0;
      @(negedge clk);
      redirect_valid = 1'b0;
    end
    while (accepted < st.n) begin
      @(negedge clk);
      fence_going = 1'b0;
      ready = 1'b1;
      if (st.rnd) begin
        lfsr  = lfsr_step(lfsr);
        ready = lfsr[0];
      end
      if (fetch_valid) begin
        if (held_v) begin
          check_bundle("fetch_o (stalled)", fetch, held);
          check_class("fetch_o.cls (stalled)", fetch.cls, held.cls);
        end
        if (ready) begin
          exp = expected_bundle(exp_pc);
          check_bundle("fetch_o", fetch, exp);
          check_class("fetch_o.cls", fetch.cls, exp.cls);
          exp_pc      = exp.pred_npc;
          accepted    = accepted + 1;
          held_v      = 1'b0;
          fence_going = (exp.cls == CLS_FENCE_I);
        end else begin
          held   = fetch;
          held_v = 1'b1;
        end
      end else if (held_v) begin
        stop_run("fetch_valid_o dropped while decode was stalling");
      end
      fetch_ready = ready;
    end
  endtask

  // refill order and residency checked on each AR and R transfer
  always @(posedge clk) begin
    logic [31:0] a;
    if (!rst) begin
      if (m_rready && !r_outstanding)
        stop_run("m_rready_o was high while no read was outstanding");
      if (m_rvalid && m_rready) begin
        r_outstanding = 1'b0;
        if (hi_pending) begin
          line_v[refill_line[1:0]]    = 1'b1;
          line_addr[refill_line[1:0]] = refill_line;
          hi_pending = 1'b0;
        end
      end
      if (m_arvalid && m_arready) begin
        a = m_ar.addr;
        r_outstanding = 1'b1;
        if (!ar_upper_next) begin
          check_addr("m_ar_o.addr (lower)", a, {a[31:3], 3'b000});
          if (line_v[a[4:3]] && line_addr[a[4:3]] == a[31:3])
            stop_run("refill was issued for a line that is already in the cache");
          line_v[a[4:3]] = 1'b0;
          refill_line    = a[31:3];
          ar_upper_next  = 1'b1;
        end else begin
          check_addr("m_ar_o.addr (upper)", a, {refill_line, 3'b100});
          ar_upper_next = 1'b0;
          hi_pending    = 1'b1;
        end
      end
      if (fence_going) begin
        for (int i = 0; i < 4; i++) line_v[i] = 1'b0;
      end
    end
  end

  initial begin
    #(CLK_NS * (16 + 200 * NUM_STEPS));
    stop_run("watchdog expired before the stimulus table was finished");
  end

  initial begin
    rst            = 1'b1;
    redirect       = '0;
    redirect_valid = 1'b0;
    fetch_ready    = 1'b0;
    lfsr           = 32'h33185de0;
    exp_pc         = PC_INIT;
    ar_upper_next  = 1'b0;
    hi_pending     = 1'b0;
    r_outstanding  = 1'b0;
    fence_going    = 1'b0;
    held_v         = 1'b0;
    refill_line    = '0;
    for (int i = 0; i < 4; i++) begin
      btb_v[i]  = 1'b0;
      line_v[i] = 1'b0;
    end
    // n, redirect (valid, pc, target, taken), backdoor (valid, addr, data), random ready
    steps[0] = '{8'd12, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b0};
    steps[1] = '{8'd8, 1'b1, 32'h58, 32'h40, 1'b1, 1'b0, 32'h0, 32'h0, 1'b0};
    steps[2] = '{8'd8, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b0};
    steps[3] = '{8'd6, 1'b1, 32'h58, 32'h5c, 1'b0, 1'b0, 32'h0, 32'h0, 1'b0};
    steps[4] = '{8'd20, 1'b1, 32'h70, 32'h80, 1'b1, 1'b0, 32'h0, 32'h0, 1'b1};
    steps[5] = '{8'd16, 1'b1, 32'h90, 32'h40, 1'b1, 1'b0, 32'h0, 32'h0, 1'b1};
    steps[6] = '{8'd0, 1'b0, 32'h0, 32'h0, 1'b0, 1'b1, 32'h100, INST_FENCE_I, 1'b0};
    // the line at 0x70 is still resident from the previous pass
    steps[7] = '{8'd2, 1'b1, 32'hfc, 32'h100, 1'b0, 1'b1, 32'h74, 32'h00a5_8463, 1'b0};
    steps[8] = '{8'd4, 1'b1, 32'h108, 32'h70, 1'b1, 1'b0, 32'h0, 32'h0, 1'b0};
    steps[9] = '{8'd12, 1'b0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h0, 32'h0, 1'b1};
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int s = 0; s < NUM_STEPS; s++) begin
      run_step(steps[s]);
    end
    @(negedge clk);
    fetch_ready = 1'b0;
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/rv_isa_pkg.sv
hdl/ifu_bus_pkg.sv
hdl/ifu_pc_gen.sv
hdl/ifu_icache.sv
hdl/ifu_predecode.sv
hdl/ifu_top.sv
sim/tb_axil_mem.sv
sim/tb_ifu_top.sv
